/* verilog.f */
design/video_pkg.sv
design/gamepad_pkg.sv
design/gamepad_receiver.sv
design/vga_timing.sv
design/square_renderer.sv
design/spacewar_top.sv
test/tb_spacewar.sv

/* Makefile */
TOP = tb_spacewar

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): verilog.f design/*.sv test/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f

# Exit status of the simulation decides pass or fail
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* test/tb_spacewar.sv */
// Testbench for the square demo top level
// Sends pad frames, rebuilds the raster and the square position,
// and checks sync, blanking and square pixels with assertions
`timescale 1ns/1ps

module tb_spacewar
  import video_pkg::*;
  import gamepad_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int FRAME_CLKS = H_TOTAL * V_TOTAL;

  // Test lengths in frames
  // Watchdog covers their sum plus one frame
  localparam int ABSENT_FRAMES   = 1;
  localparam int ONES_FRAMES     = 1;
  localparam int MOVE_FRAMES     = 3;
  localparam int OPPOSE_FRAMES   = 2;
  localparam int RETURN_FRAMES   = 5;
  localparam int TEST_FRAMES     = ABSENT_FRAMES + ONES_FRAMES + MOVE_FRAMES +
                                   OPPOSE_FRAMES + RETURN_FRAMES;
  localparam longint WATCHDOG_NS = longint'(TEST_FRAMES + 1) * FRAME_CLKS * CLK_PERIOD;

  localparam logic [COLOR_BITS-1:0] GREEN = 2'b11;
  localparam logic [COLOR_BITS-1:0] BLACK = 2'b00;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  pad_data;
  logic                  pad_clk;
  logic                  pad_latch;
  logic                  hsync;
  logic                  vsync;
  logic [COLOR_BITS-1:0] r;
  logic [COLOR_BITS-1:0] g;
  logic [COLOR_BITS-1:0] b;

  // Raster tracker and square model
  int                   th;
  int                   tv;
  logic [SLOW_BITS-1:0] slow;
  int                   mx;
  int                   my;
  buttons_t             model_btn;

  // Expected outputs lag the tracked position by one clock
  logic                  exp_hsync;
  logic                  exp_vsync;
  logic                  exp_visible;
  logic [COLOR_BITS-1:0] exp_g;
  logic [COLOR_BITS-1:0] corner_g;
  logic [COLOR_BITS-1:0] hold_g;
  int                    px_h;
  int                    hs_low;
  logic                  line_seen;

  // Stimulus state
  string       test_name;
  logic        corner_expected;
  logic        hold_expected;
  int          hold_x;
  int          hold_y;
  logic [31:0] rng;

  spacewar_top u_spacewar_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .pad_data  (pad_data),
    .pad_clk   (pad_clk),
    .pad_latch (pad_latch),
    .hsync     (hsync),
    .vsync     (vsync),
    .r         (r),
    .g         (g),
    .b         (b)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic raise_mismatch(input string what, input int expected, input int actual);
    $display("mismatch in %s: %s expected %0d actual %0d", test_name, what, expected, actual);
    $display("Done: errors found");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic abort_with(input string msg);
    $display("error in %s: %s", test_name, msg);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Random other buttons with chosen direction bits
  function automatic buttons_t random_frame(input bit up, input bit down,
                                            input bit left, input bit right);
    buttons_t frame;
    rng = xorshift(rng);
    frame = rng[PAD_BITS-1:0];
    frame[BTN_UP] = up;
    frame[BTN_DOWN] = down;
    frame[BTN_LEFT] = left;
    frame[BTN_RIGHT] = right;
    // All ones would read back as no pad
    if (frame == PAD_ABSENT) begin
      frame[BTN_A] = 1'b0;
    end
    return frame;
  endfunction

  // No pad gives no buttons
  function automatic buttons_t decode_frame(input buttons_t frame);
    return (frame == PAD_ABSENT) ? '0 : frame;
  endfunction

  function automatic bit on_screen(input int px, input int py);
    return (px < H_ACTIVE) && (py < V_ACTIVE);
  endfunction

  function automatic bit covers_pixel(input int px, input int py, input int sx, input int sy);
    return (px >= sx) && (px < sx + SQUARE_SIZE) && (py >= sy) && (py < sy + SQUARE_SIZE);
  endfunction

  // Shift MSB first with pad_clk rising mid-bit and finish with a latch pulse
  task automatic send_frame(input buttons_t frame);
    for (int i = PAD_BITS - 1; i >= 0; i--) begin
      pad_data = frame[i];
      pad_clk  = 1'b0;
      repeat (4) @(negedge clk);
      pad_clk = 1'b1;
      repeat (4) @(negedge clk);
    end
    pad_clk = 1'b0;
    repeat (4) @(negedge clk);
    pad_latch = 1'b1;
    // Buttons switch 3 clocks after the edge that first sees latch
    repeat (4) @(posedge clk);
    model_btn <= decode_frame(frame);
    @(negedge clk);
    pad_latch = 1'b0;
    pad_data  = 1'b1;
    repeat (4) @(negedge clk);
  endtask

  task automatic wait_frames(input int n);
    repeat (n * FRAME_CLKS) @(negedge clk);
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      th          <= 0;
      tv          <= 0;
      slow        <= '0;
      mx          <= 0;
      my          <= 0;
      exp_hsync   <= 1'b1;
      exp_vsync   <= 1'b1;
      exp_visible <= 1'b0;
      exp_g       <= BLACK;
      corner_g    <= BLACK;
      hold_g      <= BLACK;
      px_h        <= 0;
      hs_low      <= 0;
      line_seen   <= 1'b0;
    end else begin
      // Pixel and line count from reset
      if (th == H_TOTAL - 1) begin
        th <= 0;
        tv <= (tv == V_TOTAL - 1) ? 0 : tv + 1;
      end else begin
        th <= th + 1;
      end
      slow <= slow + 1'b1;

      // Movement tick when the counter wraps during blanking
      if ((slow == '0) && !on_screen(th, tv)) begin
        if (!(model_btn[BTN_LEFT] && model_btn[BTN_RIGHT])) begin
          if (model_btn[BTN_LEFT] && (mx > 0)) begin
            mx <= mx - 1;
          end else if (model_btn[BTN_RIGHT] && (mx < H_ACTIVE - SQUARE_SIZE)) begin
            mx <= mx + 1;
          end
        end
        if (!(model_btn[BTN_UP] && model_btn[BTN_DOWN])) begin
          if (model_btn[BTN_UP] && (my > 0)) begin
            my <= my - 1;
          end else if (model_btn[BTN_DOWN] && (my < V_ACTIVE - SQUARE_SIZE)) begin
            my <= my + 1;
          end
        end
      end

      exp_hsync   <= !((th >= H_SYNC_START) && (th < H_SYNC_END));
      exp_vsync   <= !((tv >= V_SYNC_START) && (tv < V_SYNC_END));
      exp_visible <= on_screen(th, tv);
      exp_g       <= (on_screen(th, tv) && covers_pixel(th, tv, mx, my)) ? GREEN : BLACK;
      corner_g    <= (on_screen(th, tv) && covers_pixel(th, tv, 0, 0)) ? GREEN : BLACK;
      hold_g      <= (on_screen(th, tv) && covers_pixel(th, tv, hold_x, hold_y)) ? GREEN : BLACK;
      px_h        <= th;

      // Low hsync clocks over each full line
      if (px_h == 0) begin
        hs_low <= hsync ? 0 : 1;
      end else begin
        hs_low <= hs_low + (hsync ? 0 : 1);
      end
      if (px_h == H_TOTAL - 1) begin
        line_seen <= 1'b1;
      end
    end
  end

  a_hsync_level : assert property (@(posedge clk) disable iff (!rst_n) hsync == exp_hsync)
    else raise_mismatch("hsync", int'($sampled(exp_hsync)), int'($sampled(hsync)));

  a_hsync_width : assert property (@(posedge clk) disable iff (!rst_n)
      (px_h == 0 && line_seen) |-> (hs_low == H_SYNC_END - H_SYNC_START))
    else raise_mismatch("hsync low clocks", H_SYNC_END - H_SYNC_START, $sampled(hs_low));

  a_vsync_level : assert property (@(posedge clk) disable iff (!rst_n) vsync == exp_vsync)
    else raise_mismatch("vsync", int'($sampled(exp_vsync)), int'($sampled(vsync)));

  a_blanking : assert property (@(posedge clk) disable iff (!rst_n)
      !exp_visible |-> (r == BLACK && g == BLACK && b == BLACK))
    else raise_mismatch("blanked rgb", 0, int'({$sampled(r), $sampled(g), $sampled(b)}));

  // Square is pure green
  a_green_only : assert property (@(posedge clk) disable iff (!rst_n)
      r == BLACK && b == BLACK)
    else raise_mismatch("red and blue", 0, int'({$sampled(r), $sampled(b)}));

  a_square_pixel : assert property (@(posedge clk) disable iff (!rst_n) g == exp_g)
    else raise_mismatch("green", int'($sampled(exp_g)), int'($sampled(g)));

  a_corner_pixel : assert property (@(posedge clk) disable iff (!rst_n)
      corner_expected |-> (g == corner_g))
    else raise_mismatch("green at origin", int'($sampled(corner_g)), int'($sampled(g)));

  a_hold_pixel : assert property (@(posedge clk) disable iff (!rst_n)
      hold_expected |-> (g == hold_g))
    else raise_mismatch("green while held", int'($sampled(hold_g)), int'($sampled(g)));

  initial begin
    #(WATCHDOG_NS);
    abort_with("watchdog expired before the tests finished");
  end

  initial begin
    rst_n           = 1'b0;
    pad_data        = 1'b1;
    pad_clk         = 1'b0;
    pad_latch       = 1'b0;
    model_btn       <= '0;
    rng             = 32'd43880;
    test_name       = "reset";
    corner_expected = 1'b0;
    hold_expected   = 1'b0;
    hold_x          = 0;
    hold_y          = 0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // Idle pad lines keep the square at the origin
    test_name       = "absent_pad";
    corner_expected = 1'b1;
    wait_frames(ABSENT_FRAMES);
    test_name = "all_ones_frame";
    send_frame(PAD_ABSENT);
    wait_frames(ONES_FRAMES);
    corner_expected = 1'b0;

    test_name = "right_down";
    send_frame(random_frame(1'b0, 1'b1, 1'b0, 1'b1));
    wait_frames(MOVE_FRAMES);
    if (mx == 0 || my == 0) begin
      abort_with("square never left the origin");
    end

    // All four directions held so the position stays frozen
    test_name = "opposing";
    send_frame(random_frame(1'b1, 1'b1, 1'b1, 1'b1));
    hold_x = mx;
    hold_y = my;
    @(negedge clk);
    hold_expected = 1'b1;
    wait_frames(OPPOSE_FRAMES);
    hold_expected = 1'b0;

    // Back to the origin and clamped there
    test_name = "left_up";
    send_frame(random_frame(1'b1, 1'b0, 1'b1, 1'b0));
    for (int n = 0; n < RETURN_FRAMES * FRAME_CLKS; n++) begin
      @(negedge clk);
      if (!corner_expected && mx == 0 && my == 0) begin
        corner_expected = 1'b1;
      end
    end

    if (!corner_expected) begin
      abort_with("square did not return to the origin");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

/* design/spacewar_top.sv */
// Square demo top level
// Gamepad receiver, VGA timing and square renderer
`timescale 1ns/1ps

module spacewar_top (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       pad_data,
  input  logic       pad_clk,
  input  logic       pad_latch,
  output logic       hsync,
  output logic       vsync,
  output logic [1:0] r,
  output logic [1:0] g,
  output logic [1:0] b
);

  gamepad_pkg::buttons_t buttons;
  logic                  pad_present;

  logic [video_pkg::POS_BITS-1:0] hpos;
  logic [video_pkg::POS_BITS-1:0] vpos;
  logic                           display_on;

  gamepad_receiver u_receiver (
    .clk         (clk),
    .rst_n       (rst_n),
    .pad_data    (pad_data),
    .pad_clk     (pad_clk),
    .pad_latch   (pad_latch),
    .buttons     (buttons),
    .pad_present (pad_present)
  );

  vga_timing u_timing (
    .clk        (clk),
    .rst_n      (rst_n),
    .hpos       (hpos),
    .vpos       (vpos),
    .display_on (display_on),
    .hsync      (hsync),
    .vsync      (vsync)
  );

  // Colour out is registered to match the sync delay
  square_renderer u_renderer (
    .clk         (clk),
    .rst_n       (rst_n),
    .buttons     (buttons),
    .pad_present (pad_present),
    .hpos        (hpos),
    .vpos        (vpos),
    .display_on  (display_on),
    .r           (r),
    .g           (g),
    .b           (b)
  );

endmodule

/* design/square_renderer.sv */
// Moving square renderer
// Steps a 16x16 square under direction-button control during
// blanking and paints it green on black
`timescale 1ns/1ps

module square_renderer
  import video_pkg::*;
  import gamepad_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  buttons_t              buttons,
  input  logic                  pad_present,
  input  logic [POS_BITS-1:0]   hpos,
  input  logic [POS_BITS-1:0]   vpos,
  input  logic                  display_on,
  output logic [COLOR_BITS-1:0] r,
  output logic [COLOR_BITS-1:0] g,
  output logic [COLOR_BITS-1:0] b
);

  // Furthest top-left corner that keeps the square on screen
  localparam logic [POS_BITS-1:0] X_LIMIT = POS_BITS'(H_ACTIVE - SQUARE_SIZE);
  localparam logic [POS_BITS-1:0] Y_LIMIT = POS_BITS'(V_ACTIVE - SQUARE_SIZE);
  localparam logic [POS_BITS-1:0] SIZE    = POS_BITS'(SQUARE_SIZE);

  logic [SLOW_BITS-1:0] slow_cnt;
  logic                 tick;

  logic [POS_BITS-1:0] sq_x;
  logic [POS_BITS-1:0] sq_y;

  logic btn_up;
  logic btn_down;
  logic btn_left;
  logic btn_right;

  logic in_square;
  logic paint;

  // Free-running pace counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      slow_cnt <= '0;
    end else begin
      slow_cnt <= slow_cnt + 1'b1;
    end
  end

  // Move only while blanked so a frame never tears
  assign tick = (slow_cnt == '0) && !display_on;

  assign btn_up    = buttons[BTN_UP];
  assign btn_down  = buttons[BTN_DOWN];
  assign btn_left  = buttons[BTN_LEFT];
  assign btn_right = buttons[BTN_RIGHT];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sq_x <= '0;
      sq_y <= '0;
    end else if (tick && pad_present) begin
      // Opposite buttons together cancel out
      if (btn_left && btn_right) begin
        sq_x <= sq_x;
      end else if (btn_left && (sq_x > '0)) begin
        sq_x <= sq_x - 1'b1;
      end else if (btn_right && (sq_x < X_LIMIT)) begin
        sq_x <= sq_x + 1'b1;
      end

      if (btn_up && btn_down) begin
        sq_y <= sq_y;
      end else if (btn_up && (sq_y > '0)) begin
        sq_y <= sq_y - 1'b1;
      end else if (btn_down && (sq_y < Y_LIMIT)) begin
        sq_y <= sq_y + 1'b1;
      end
    end
  end

  // Corner plus size stays within 10 bits since corner is clamped
  assign in_square = (hpos >= sq_x) && (hpos < sq_x + SIZE) &&
                     (vpos >= sq_y) && (vpos < sq_y + SIZE);
  assign paint = display_on && in_square;

  // One clock behind hpos/vpos, in step with hsync/vsync
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r <= COLOR_OFF;
      g <= COLOR_OFF;
      b <= COLOR_OFF;
    end else begin
      r <= paint ? SQUARE_R : COLOR_OFF;
      g <= paint ? SQUARE_G : COLOR_OFF;
      b <= paint ? SQUARE_B : COLOR_OFF;
    end
  end

  // Square never leaves the visible area
  a_square_on_screen : assert property (
    @(posedge clk) disable iff (!rst_n) (sq_x <= X_LIMIT) && (sq_y <= Y_LIMIT)
  );

endmodule

/* design/vga_timing.sv */
// VGA timing generator
// Pixel and line counters for a 640x480 raster with
// registered active-low sync pulses
`timescale 1ns/1ps

module vga_timing
  import video_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  output logic [POS_BITS-1:0] hpos,
  output logic [POS_BITS-1:0] vpos,
  output logic                display_on,
  output logic                hsync,
  output logic                vsync
);

  logic [POS_BITS-1:0] h_count;
  logic [POS_BITS-1:0] v_count;
  logic                h_last;
  logic                v_last;

  assign h_last = (h_count == POS_BITS'(H_TOTAL - 1));
  assign v_last = (v_count == POS_BITS'(V_TOTAL - 1));

  // Pixel counter, line counter steps at end of each line
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_count <= '0;
      v_count <= '0;
    end else begin
      if (h_last) begin
        h_count <= '0;
        if (v_last) begin
          v_count <= '0;
        end else begin
          v_count <= v_count + 1'b1;
        end
      end else begin
        h_count <= h_count + 1'b1;
      end
    end
  end

  // Sync lags the counters by one clock, same as the colour
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hsync <= 1'b1;
      vsync <= 1'b1;
    end else begin
      hsync <= !((h_count >= POS_BITS'(H_SYNC_START)) && (h_count < POS_BITS'(H_SYNC_END)));
      vsync <= !((v_count >= POS_BITS'(V_SYNC_START)) && (v_count < POS_BITS'(V_SYNC_END)));
    end
  end

  assign hpos = h_count;
  assign vpos = v_count;

  // Visible area only
  assign display_on = (h_count < POS_BITS'(H_ACTIVE)) && (v_count < POS_BITS'(V_ACTIVE));

  // Renderer compares against these, so they must stay in the frame
  a_pos_in_frame : assert property (
    @(posedge clk) disable iff (!rst_n)
      (hpos < POS_BITS'(H_TOTAL)) && (vpos < POS_BITS'(V_TOTAL))
  );

endmodule

/* design/gamepad_receiver.sv */
// Gamepad serial receiver
// Synchronises the pad lines, assembles a 12-bit frame and
// decodes pad presence and the button vector
`timescale 1ns/1ps

module gamepad_receiver
  import gamepad_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     pad_data,
  input  logic     pad_clk,
  input  logic     pad_latch,
  output buttons_t buttons,
  output logic     pad_present
);

  // Two-flop synchronisers, bit 1 is the safe copy
  logic [1:0] data_sync;
  logic [1:0] clk_sync;
  logic [1:0] latch_sync;

  // Previous synchronised levels for edge detect
  logic clk_prev;
  logic latch_prev;

  logic clk_rise;
  logic latch_rise;

  buttons_t shift_reg;
  buttons_t frame_reg;
  logic     frame_absent;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_sync  <= '0;
      clk_sync   <= '0;
      latch_sync <= '0;
      clk_prev   <= 1'b0;
      latch_prev <= 1'b0;
    end else begin
      data_sync  <= {data_sync[0], pad_data};
      clk_sync   <= {clk_sync[0], pad_clk};
      latch_sync <= {latch_sync[0], pad_latch};
      clk_prev   <= clk_sync[1];
      latch_prev <= latch_sync[1];
    end
  end

  assign clk_rise   = clk_sync[1] & ~clk_prev;
  assign latch_rise = latch_sync[1] & ~latch_prev;

  // Both start as all ones so an idle line reads as no pad
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shift_reg <= PAD_ABSENT;
      frame_reg <= PAD_ABSENT;
    end else begin
      // New bit enters at the low end
      if (clk_rise) begin
        shift_reg <= {shift_reg[PAD_BITS-2:0], data_sync[1]};
      end
      if (latch_rise) begin
        frame_reg <= shift_reg;
      end
    end
  end

  assign frame_absent = (frame_reg == PAD_ABSENT);

  // Registered decode, third clock after latch is first seen
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      buttons     <= '0;
      pad_present <= 1'b0;
    end else begin
      pad_present <= !frame_absent;
      buttons     <= frame_absent ? '0 : frame_reg;
    end
  end

  // No pad means no buttons reach the renderer
  a_absent_no_buttons : assert property (
    @(posedge clk) disable iff (!rst_n) !pad_present |-> (buttons == '0)
  );

endmodule

/* design/gamepad_pkg.sv */
// Gamepad frame definitions
// Serial frame width, button vector and button bit positions
package gamepad_pkg;

  // Bits shifted in per pad frame
  localparam int PAD_BITS = 12;

  // One bit per button, 1 = pressed
  typedef logic [PAD_BITS-1:0] buttons_t;

  // First bit shifted in lands at the top
  localparam int BTN_B      = 11;
  localparam int BTN_Y      = 10;
  localparam int BTN_SELECT = 9;
  localparam int BTN_START  = 8;
  localparam int BTN_UP     = 7;
  localparam int BTN_DOWN   = 6;
  localparam int BTN_LEFT   = 5;
  localparam int BTN_RIGHT  = 4;
  localparam int BTN_A      = 3;
  localparam int BTN_X      = 2;
  localparam int BTN_L      = 1;
  localparam int BTN_R      = 0;

  // Frame read back when no pad is plugged in
  localparam buttons_t PAD_ABSENT = '1;

endpackage

/* design/video_pkg.sv */
// Video constants for the square demo
// 640x480 raster timing, square geometry and pixel colours
package video_pkg;

  // Raster size in pixels and lines
  localparam int H_ACTIVE = 640;
  localparam int H_TOTAL  = 800;
  localparam int V_ACTIVE = 480;
  localparam int V_TOTAL  = 525;

  // Sync pulses, active low, end is exclusive
  localparam int H_SYNC_START = 656;
  localparam int H_SYNC_END   = 752;
  localparam int V_SYNC_START = 490;
  localparam int V_SYNC_END   = 492;

  // Width of every pixel or line coordinate
  localparam int POS_BITS = 10;

  // Square edge length in pixels
  localparam int SQUARE_SIZE = 16;

  // Free-running counter that paces movement
  localparam int SLOW_BITS = 14;

  // Per-channel colour depth and the square colour
  localparam int COLOR_BITS = 2;
  localparam logic [COLOR_BITS-1:0] COLOR_OFF = 2'b00;
  localparam logic [COLOR_BITS-1:0] SQUARE_R  = 2'b00;
  localparam logic [COLOR_BITS-1:0] SQUARE_G  = 2'b11;
  localparam logic [COLOR_BITS-1:0] SQUARE_B  = 2'b00;

endpackage
